//--- files.f
+incdir+common
common/wb_stage_pkg.sv
writeback/writeback.sv
writeback/repne_count_logic.sv
writeback/flags_wb.sv
src/gpr_file.sv
src/data_mem.sv
src/wb_subsystem_top.sv
verification/tb_wb_subsystem.sv

//--- verification/tb_wb_subsystem.sv
// writeback subsystem testbench
`include "wb_stage_params.svh"

module tb_wb_subsystem;

   localparam int RESET_CYCLES = 8;
   localparam int IDLE_GAP     = 8;
   localparam int MEM_AW       = $clog2(`WB_MEM_WORDS);
   // test length in slots of one uop or one idle cycle
   localparam int ALU_SLOTS    = 9 + IDLE_GAP;
   localparam int FLAG_SLOTS   = 6;
   localparam int STORE_SLOTS  = 6;
   localparam int CMPS_SLOTS   = 6 * (3 + IDLE_GAP);
   localparam int REP_SLOTS    = 2 + 4 * (2 + IDLE_GAP) + IDLE_GAP;
   localparam int TOTAL_SLOTS  = ALU_SLOTS + FLAG_SLOTS + STORE_SLOTS + CMPS_SLOTS + REP_SLOTS;
   localparam int MAX_CYCLES   = 2 * 2 * TOTAL_SLOTS + RESET_CYCLES;

   logic                     CLK;
   logic                     rst_n;
   logic                     uop_v;
   wb_stage_pkg::wb_uop_t    uop;
   logic                     uop_ready;
   logic                     rep_done;
   logic [`WB_XLEN-1:0]      flags;
   logic [`WB_GPR_IDX_W-1:0] gpr_dbg_idx;
   logic [`WB_XLEN-1:0]      gpr_dbg_data;
   logic [`WB_XLEN-1:0]      mem_dbg_adr;
   logic [`WB_XLEN-1:0]      mem_dbg_data;

   // reference model state
   logic [`WB_XLEN-1:0] m_regs [`WB_NUM_GPR];
   logic [`WB_XLEN-1:0] m_mem [`WB_MEM_WORDS];
   logic                m_mem_vld [`WB_MEM_WORDS];
   logic [`WB_XLEN-1:0] m_flags;
   logic [`WB_XLEN-1:0] m_count;
   logic [`WB_XLEN-1:0] m_temp;
   logic                m_rep_done;
   logic                m_store_wait;
   logic                acc_q;
   logic                exp_ready;
   integer              seed;
   int                  cycles = 0;

   wb_subsystem_top dut0 (
      .CLK(CLK), .rst_n(rst_n), .uop_v(uop_v), .uop(uop), .uop_ready(uop_ready),
      .rep_done(rep_done), .flags(flags), .gpr_dbg_idx(gpr_dbg_idx),
      .gpr_dbg_data(gpr_dbg_data), .mem_dbg_adr(mem_dbg_adr), .mem_dbg_data(mem_dbg_data)
   );

   always #50 CLK = ~CLK;

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, got);
      abort_run();
   endtask

   function automatic logic [31:0] flag_mask(input logic [6:0] aff);
      logic [31:0] m;
      m = '0;
      m[`WB_FLAG_OF] = aff[6];
      m[`WB_FLAG_DF] = aff[5];
      m[`WB_FLAG_SF] = aff[4];
      m[`WB_FLAG_ZF] = aff[3];
      m[`WB_FLAG_AF] = aff[2];
      m[`WB_FLAG_PF] = aff[1];
      m[`WB_FLAG_CF] = aff[0];
      return m;
   endfunction

   // commit one accepted uop into the model
   task automatic apply_uop(input wb_stage_pkg::wb_uop_t u);
      logic [31:0] step;
      logic [31:0] adv;
      logic [31:0] new_cnt;
      logic        zf;
      step = (u.datasize == wb_stage_pkg::SIZE_BYTE) ? 32'd1 :
             (u.datasize == wb_stage_pkg::SIZE_WORD) ? 32'd2 : 32'd4;
      adv  = m_flags[`WB_FLAG_DF] ? u.pointer - step : u.pointer + step;
      zf   = (u.ld_flags && u.flags_affected[3]) ? u.new_flags[`WB_FLAG_ZF] :
             m_flags[`WB_FLAG_ZF];
      case (u.kind)
         wb_stage_pkg::UOP_ALU:
            if (u.ld_gpr1) m_regs[u.dr1] = u.alu_result;
         wb_stage_pkg::UOP_STORE: begin
            m_mem[u.address[MEM_AW+1:2]]     = u.alu_result;
            m_mem_vld[u.address[MEM_AW+1:2]] = 1'b1;
         end
         wb_stage_pkg::UOP_CMPS_FIRST:
            m_temp = adv;
         wb_stage_pkg::UOP_CMPS_SECOND: begin
            new_cnt = m_count - 32'd1;
            if (u.ld_gpr1) m_regs[u.dr1] = m_temp;
            if (u.ld_gpr2) m_regs[u.dr2] = adv;
            if (u.ld_gpr3) m_regs[u.dr3] = new_cnt;
            m_count    = new_cnt;
            m_rep_done = (new_cnt == 32'd0) || zf;
         end
         wb_stage_pkg::UOP_REP_START:
            m_count = u.count;
         default: ;
      endcase
      if (u.ld_flags)
         m_flags = (m_flags & ~flag_mask(u.flags_affected)) |
                   (u.new_flags & flag_mask(u.flags_affected));
   endtask

   function automatic wb_stage_pkg::wb_uop_t new_uop(input wb_stage_pkg::uop_kind_t kind);
      wb_stage_pkg::wb_uop_t u;
      u            = '0;
      u.kind       = kind;
      u.datasize   = wb_stage_pkg::SIZE_DWORD;
      u.alu_result = $random(seed);
      return u;
   endfunction

   // present a uop and hold it until the handshake
   task automatic send_uop(input wb_stage_pkg::wb_uop_t u);
      logic ready_seen;
      uop        = u;
      uop_v      = 1'b1;
      ready_seen = 1'b0;
      while (!ready_seen) begin
         @(negedge CLK);
         ready_seen = uop_ready;
         @(posedge CLK);
      end
      #1;
      uop_v = 1'b0;
   endtask

   // uop_v low with a writing ALU uop on the bus
   task automatic idle_cycles(input int n);
      uop         = new_uop(wb_stage_pkg::UOP_ALU);
      uop.ld_gpr1 = 1'b1;
      uop_v       = 1'b0;
      repeat (n) @(posedge CLK);
      #1;
   endtask

   task automatic cmps_pair(input wb_stage_pkg::data_size_t size, input logic set_zf);
      wb_stage_pkg::wb_uop_t u;
      u          = new_uop(wb_stage_pkg::UOP_CMPS_FIRST);
      u.datasize = size;
      u.pointer  = $random(seed);
      u.ld_gpr1  = 1'b1;
      u.ld_gpr2  = 1'b1;
      u.ld_gpr3  = 1'b1;
      send_uop(u);
      // gap lets the rotating debug read visit every register
      idle_cycles(IDLE_GAP);
      u                = new_uop(wb_stage_pkg::UOP_CMPS_SECOND);
      u.datasize       = size;
      u.pointer        = $random(seed);
      u.dr1            = 3'd1;
      u.dr2            = 3'd2;
      u.dr3            = 3'd3;
      u.ld_gpr1        = 1'b1;
      u.ld_gpr2        = 1'b1;
      u.ld_gpr3        = 1'b1;
      u.ld_flags       = set_zf;
      u.flags_affected = 7'b0001000;
      u.new_flags      = 32'h1 << `WB_FLAG_ZF;
      send_uop(u);
   endtask

   // store keeps ready low for its first cycle only
   assign exp_ready = !(uop_v && uop.kind == wb_stage_pkg::UOP_STORE && !m_store_wait);

   always @(posedge CLK) begin
      m_rep_done = 1'b0;
      if (rst_n && acc_q) begin
         apply_uop(uop);
         m_store_wait = 1'b0;
      end else if (rst_n && uop_v && uop.kind == wb_stage_pkg::UOP_STORE) begin
         m_store_wait = 1'b1;
      end
   end

   always @(posedge CLK) begin
      #1;
      gpr_dbg_idx = gpr_dbg_idx + 1'b1;
   end

   always @(negedge CLK) begin
      acc_q = uop_v && uop_ready;
      if (rst_n) begin
         assert (gpr_dbg_data === m_regs[gpr_dbg_idx])
            else report_mismatch("gpr_dbg_data", m_regs[gpr_dbg_idx], gpr_dbg_data);
         assert (flags === m_flags) else report_mismatch("flags", m_flags, flags);
         assert (rep_done === m_rep_done) else report_mismatch("rep_done", m_rep_done, rep_done);
         assert (uop_ready === exp_ready)
            else report_mismatch("uop_ready", exp_ready, uop_ready);
         if (m_mem_vld[mem_dbg_adr[MEM_AW+1:2]])
            assert (mem_dbg_data === m_mem[mem_dbg_adr[MEM_AW+1:2]])
               else report_mismatch("mem_dbg_data", m_mem[mem_dbg_adr[MEM_AW+1:2]],
                                    mem_dbg_data);
      end
   end

   always @(posedge CLK) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run hung after %0d cycles", cycles);
         abort_run();
      end
   end

   initial begin
      wb_stage_pkg::wb_uop_t u;
      seed        = 32'hfaaf_37c5;
      CLK         = 1'b0;
      rst_n       = 1'b0;
      uop_v       = 1'b0;
      uop         = '0;
      gpr_dbg_idx = '0;
      mem_dbg_adr = '0;
      m_flags      = '0;
      m_count      = '0;
      m_temp       = '0;
      m_rep_done   = 1'b0;
      m_store_wait = 1'b0;
      acc_q        = 1'b0;
      for (int i = 0; i < `WB_NUM_GPR; i++) m_regs[i] = '0;
      for (int i = 0; i < `WB_MEM_WORDS; i++) m_mem_vld[i] = 1'b0;
      repeat (RESET_CYCLES) @(posedge CLK);
      #1;
      rst_n = 1'b1;

      // alu writeback then one uop with no ld bits
      for (int i = 0; i < 8; i++) begin
         u         = new_uop(wb_stage_pkg::UOP_ALU);
         u.dr1     = $random(seed);
         u.ld_gpr1 = 1'b1;
         send_uop(u);
      end
      u = new_uop(wb_stage_pkg::UOP_ALU);
      send_uop(u);
      idle_cycles(IDLE_GAP);

      // masked flags
      for (int i = 0; i < FLAG_SLOTS; i++) begin
         u                = new_uop(wb_stage_pkg::UOP_ALU);
         u.ld_flags       = 1'b1;
         u.new_flags      = $random(seed);
         u.flags_affected = $random(seed);
         send_uop(u);
      end

      // stores to distinct words
      for (int i = 0; i < STORE_SLOTS; i++) begin
         u         = new_uop(wb_stage_pkg::UOP_STORE);
         u.address = 32'h40 + 4 * i;
         send_uop(u);
         mem_dbg_adr = u.address;
      end

      // cmps over both directions and all sizes
      for (int df = 0; df < 2; df++) begin
         for (int sz = 0; sz < 3; sz++) begin
            u                = new_uop(wb_stage_pkg::UOP_ALU);
            u.ld_flags       = 1'b1;
            u.flags_affected = 7'b0100000;
            u.new_flags      = df << `WB_FLAG_DF;
            send_uop(u);
            cmps_pair(wb_stage_pkg::data_size_t'(sz), 1'b0);
         end
      end

      // repne ends on zero count and then on ZF
      u                = new_uop(wb_stage_pkg::UOP_REP_START);
      u.count          = 32'd3;
      u.ld_flags       = 1'b1;
      u.flags_affected = 7'b0101000;
      send_uop(u);
      repeat (3) cmps_pair(wb_stage_pkg::SIZE_BYTE, 1'b0);
      u       = new_uop(wb_stage_pkg::UOP_REP_START);
      u.count = 32'd5;
      send_uop(u);
      cmps_pair(wb_stage_pkg::SIZE_WORD, 1'b1);
      // debug read sweeps the registers of the last pair
      idle_cycles(IDLE_GAP);

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- src/wb_subsystem_top.sv
// writeback subsystem top
`include "wb_stage_params.svh"

module wb_subsystem_top (
   input  logic                     CLK,
   input  logic                     rst_n,
   input  logic                     uop_v,
   input  wb_stage_pkg::wb_uop_t    uop,
   output logic                     uop_ready,
   output logic                     rep_done,
   output logic [`WB_XLEN-1:0]      flags,
   input  logic [`WB_GPR_IDX_W-1:0] gpr_dbg_idx,
   output logic [`WB_XLEN-1:0]      gpr_dbg_data,
   input  logic [`WB_XLEN-1:0]      mem_dbg_adr,
   output logic [`WB_XLEN-1:0]      mem_dbg_data
);

   // ZF slot in the affected mask
   localparam int ZF_AFF_BIT = 3;

   wb_stage_pkg::gpr_wr_t  gpr1;
   wb_stage_pkg::gpr_wr_t  gpr2;
   wb_stage_pkg::gpr_wr_t  gpr3;
   wb_stage_pkg::wbm_req_t wbm_req;
   wb_stage_pkg::wbm_rsp_t wbm_rsp;
   logic                   flags_we;
   logic                   count_load;
   logic                   count_dec;
   logic                   commit_zf;
   logic [`WB_XLEN-1:0]    count;

   // ZF as it will stand after this uop commits
   assign commit_zf = (uop.ld_flags && uop.flags_affected[ZF_AFF_BIT]) ?
                      uop.new_flags[`WB_FLAG_ZF] : flags[`WB_FLAG_ZF];

   writeback u_writeback (
      .CLK(CLK), .rst_n(rst_n), .uop_v(uop_v), .uop(uop), .uop_ready(uop_ready),
      .cur_flags(flags), .cur_count(count), .gpr1(gpr1), .gpr2(gpr2), .gpr3(gpr3),
      .flags_we(flags_we), .count_load(count_load), .count_dec(count_dec),
      .wbm_req(wbm_req), .wbm_rsp(wbm_rsp)
   );

   flags_wb u_flags_wb (
      .CLK(CLK), .rst_n(rst_n), .flags_we(flags_we), .new_flags(uop.new_flags),
      .flags_affected(uop.flags_affected), .flags(flags)
   );

   repne_count_logic u_repne_count_logic (
      .CLK(CLK), .rst_n(rst_n), .count_load(count_load), .load_value(uop.count),
      .count_dec(count_dec), .commit_zf(commit_zf), .count(count), .rep_done(rep_done)
   );

   gpr_file u_gpr_file (
      .CLK(CLK), .rst_n(rst_n), .wr1(gpr1), .wr2(gpr2), .wr3(gpr3),
      .dbg_idx(gpr_dbg_idx), .dbg_data(gpr_dbg_data)
   );

   data_mem u_data_mem (
      .CLK(CLK), .rst_n(rst_n), .wbs_req(wbm_req), .wbs_rsp(wbm_rsp),
      .dbg_adr(mem_dbg_adr), .dbg_data(mem_dbg_data)
   );

endmodule

//--- src/data_mem.sv
// wishbone data memory
`include "wb_stage_params.svh"

module data_mem (
   input  logic                   CLK,
   input  logic                   rst_n,
   input  wb_stage_pkg::wbm_req_t wbs_req,
   output wb_stage_pkg::wbm_rsp_t wbs_rsp,
   input  logic [`WB_XLEN-1:0]    dbg_adr,
   output logic [`WB_XLEN-1:0]    dbg_data
);

   localparam int AW = $clog2(`WB_MEM_WORDS);

   logic [`WB_XLEN-1:0] mem [`WB_MEM_WORDS];
   logic [AW-1:0]       word_idx;
   logic                ack;
   logic                hit;
   logic [`WB_XLEN-1:0] rd_data;

   assign word_idx = wbs_req.adr[AW+1:2];
   // one access per strobe, ack drops for a cycle between
   assign hit = wbs_req.cyc && wbs_req.stb && !ack;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= hit;
      end
   end

   always_ff @(posedge CLK) begin
      if (hit && wbs_req.we) begin
         for (int b = 0; b < 4; b++) begin
            if (wbs_req.sel[b]) begin
               mem[word_idx][8*b +: 8] <= wbs_req.dat[8*b +: 8];
            end
         end
      end
      if (hit && !wbs_req.we) begin
         rd_data <= mem[word_idx];
      end
   end

   assign wbs_rsp.ack = ack;
   assign wbs_rsp.dat = rd_data;
   assign dbg_data    = mem[dbg_adr[AW+1:2]];

endmodule

//--- src/gpr_file.sv
// general register file
`include "wb_stage_params.svh"

module gpr_file (
   input  logic                     CLK,
   input  logic                     rst_n,
   input  wb_stage_pkg::gpr_wr_t    wr1,
   input  wb_stage_pkg::gpr_wr_t    wr2,
   input  wb_stage_pkg::gpr_wr_t    wr3,
   input  logic [`WB_GPR_IDX_W-1:0] dbg_idx,
   output logic [`WB_XLEN-1:0]      dbg_data
);

   logic [`WB_XLEN-1:0] regs [`WB_NUM_GPR];

   // later port overrides earlier one on the same index
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `WB_NUM_GPR; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wr1.en) begin
            regs[wr1.idx] <= wr1.data;
         end
         if (wr2.en) begin
            regs[wr2.idx] <= wr2.data;
         end
         if (wr3.en) begin
            regs[wr3.idx] <= wr3.data;
         end
      end
   end

   assign dbg_data = regs[dbg_idx];

endmodule

//--- writeback/flags_wb.sv
// masked flags register
`include "wb_stage_params.svh"

module flags_wb (
   input  logic                CLK,
   input  logic                rst_n,
   input  logic                flags_we,
   input  logic [`WB_XLEN-1:0] new_flags,
   input  logic [6:0]          flags_affected,
   output logic [`WB_XLEN-1:0] flags
);

   logic [`WB_XLEN-1:0] upd_mask;

   // spread the 7-bit mask onto the flag positions
   always_comb begin
      upd_mask               = '0;
      upd_mask[`WB_FLAG_OF]  = flags_affected[6];
      upd_mask[`WB_FLAG_DF]  = flags_affected[5];
      upd_mask[`WB_FLAG_SF]  = flags_affected[4];
      upd_mask[`WB_FLAG_ZF]  = flags_affected[3];
      upd_mask[`WB_FLAG_AF]  = flags_affected[2];
      upd_mask[`WB_FLAG_PF]  = flags_affected[1];
      upd_mask[`WB_FLAG_CF]  = flags_affected[0];
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         flags <= '0;
      end else if (flags_we) begin
         flags <= (flags & ~upd_mask) | (new_flags & upd_mask);
      end
   end

endmodule

//--- writeback/repne_count_logic.sv
// REPNE counter and termination
`include "wb_stage_params.svh"

module repne_count_logic (
   input  logic                CLK,
   input  logic                rst_n,
   input  logic                count_load,
   input  logic [`WB_XLEN-1:0] load_value,
   input  logic                count_dec,
   input  logic                commit_zf,
   output logic [`WB_XLEN-1:0] count,
   output logic                rep_done
);

   logic [`WB_XLEN-1:0] count_nxt;

   assign count_nxt = count - 1'b1;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         count    <= '0;
         rep_done <= 1'b0;
      end else begin
         // stop on zero count or a match
         rep_done <= count_dec && ((count_nxt == '0) || commit_zf);
         if (count_load) begin
            count <= load_value;
         end else if (count_dec) begin
            count <= count_nxt;
         end
      end
   end

endmodule

//--- writeback/writeback.sv
// writeback stage control and steering
`include "wb_stage_params.svh"

module writeback (
   input  logic                   CLK,
   input  logic                   rst_n,
   input  logic                   uop_v,
   input  wb_stage_pkg::wb_uop_t  uop,
   output logic                   uop_ready,
   input  logic [`WB_XLEN-1:0]    cur_flags,
   input  logic [`WB_XLEN-1:0]    cur_count,
   output wb_stage_pkg::gpr_wr_t  gpr1,
   output wb_stage_pkg::gpr_wr_t  gpr2,
   output wb_stage_pkg::gpr_wr_t  gpr3,
   output logic                   flags_we,
   output logic                   count_load,
   output logic                   count_dec,
   output wb_stage_pkg::wbm_req_t wbm_req,
   input  wb_stage_pkg::wbm_rsp_t wbm_rsp
);

   wb_stage_pkg::wbm_state_t state;
   wb_stage_pkg::wbm_state_t state_nxt;
   logic                     store_req;
   logic                     accept;
   logic                     is_cmps1;
   logic                     is_cmps2;
   logic [`WB_XLEN-1:0]      step;
   logic [`WB_XLEN-1:0]      adv_ptr;
   logic [`WB_XLEN-1:0]      temp_ptr;
   logic [4:0]               lane_shift;

   assign store_req = uop_v && (uop.kind == wb_stage_pkg::UOP_STORE);
   assign is_cmps1  = uop.kind == wb_stage_pkg::UOP_CMPS_FIRST;
   assign is_cmps2  = uop.kind == wb_stage_pkg::UOP_CMPS_SECOND;

   // a store is held until the slave acks it
   assign uop_ready = !store_req || (state == wb_stage_pkg::WBM_WAIT_ACK && wbm_rsp.ack);
   assign accept    = uop_v && uop_ready;

   always_comb begin
      state_nxt = state;
      case (state)
         wb_stage_pkg::WBM_IDLE:     if (store_req) state_nxt = wb_stage_pkg::WBM_WAIT_ACK;
         wb_stage_pkg::WBM_WAIT_ACK: if (wbm_rsp.ack) state_nxt = wb_stage_pkg::WBM_IDLE;
         default:                    state_nxt = wb_stage_pkg::WBM_IDLE;
      endcase
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         state <= wb_stage_pkg::WBM_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // byte lanes follow datasize and the low address bits
   always_comb begin
      wbm_req.cyc = (state == wb_stage_pkg::WBM_WAIT_ACK) || store_req;
      wbm_req.stb = wbm_req.cyc;
      wbm_req.we  = 1'b1;
      wbm_req.adr = uop.address;
      case (uop.datasize)
         wb_stage_pkg::SIZE_BYTE: begin
            lane_shift  = {uop.address[1:0], 3'b000};
            wbm_req.sel = 4'b0001 << uop.address[1:0];
         end
         wb_stage_pkg::SIZE_WORD: begin
            lane_shift  = {uop.address[1], 4'b0000};
            wbm_req.sel = 4'b0011 << {uop.address[1], 1'b0};
         end
         default: begin
            lane_shift  = 5'd0;
            wbm_req.sel = 4'b1111;
         end
      endcase
      wbm_req.dat = uop.alu_result << lane_shift;
   end

   // cmps pointer advance, DF set walks down
   always_comb begin
      case (uop.datasize)
         wb_stage_pkg::SIZE_BYTE: step = `WB_XLEN'd1;
         wb_stage_pkg::SIZE_WORD: step = `WB_XLEN'd2;
         default:                 step = `WB_XLEN'd4;
      endcase
      adv_ptr = cur_flags[`WB_FLAG_DF] ? uop.pointer - step : uop.pointer + step;
   end

   // first cmps pointer waits here for the second uop
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         temp_ptr <= '0;
      end else if (accept && is_cmps1) begin
         temp_ptr <= adv_ptr;
      end
   end

   always_comb begin
      gpr1.en   = accept && uop.ld_gpr1 && !is_cmps1;
      gpr1.idx  = uop.dr1;
      gpr1.data = is_cmps2 ? temp_ptr : uop.alu_result;
      gpr2.en   = accept && uop.ld_gpr2 && !is_cmps1;
      gpr2.idx  = uop.dr2;
      gpr2.data = adv_ptr;
      gpr3.en   = accept && uop.ld_gpr3 && !is_cmps1;
      gpr3.idx  = uop.dr3;
      gpr3.data = cur_count - 1'b1;
   end

   assign flags_we   = accept && uop.ld_flags;
   assign count_load = accept && (uop.kind == wb_stage_pkg::UOP_REP_START);
   assign count_dec  = accept && is_cmps2;

endmodule

//--- common/wb_stage_pkg.sv
// writeback stage types
`include "wb_stage_params.svh"

package wb_stage_pkg;

   // micro-op kinds seen by writeback
   typedef enum logic [2:0] {
      UOP_ALU,
      UOP_STORE,
      UOP_CMPS_FIRST,
      UOP_CMPS_SECOND,
      UOP_REP_START
   } uop_kind_t;

   // operand size, pointer step 1/2/4
   typedef enum logic [1:0] {
      SIZE_BYTE,
      SIZE_WORD,
      SIZE_DWORD
   } data_size_t;

   // store master states
   typedef enum logic {
      WBM_IDLE,
      WBM_WAIT_ACK
   } wbm_state_t;

   typedef struct packed {
      uop_kind_t                kind;
      data_size_t               datasize;
      logic [`WB_GPR_IDX_W-1:0] dr1;
      logic [`WB_GPR_IDX_W-1:0] dr2;
      logic [`WB_GPR_IDX_W-1:0] dr3;
      logic                     ld_gpr1;
      logic                     ld_gpr2;
      logic                     ld_gpr3;
      logic                     ld_flags;
      logic [`WB_XLEN-1:0]      alu_result;
      logic [`WB_XLEN-1:0]      pointer;
      logic [`WB_XLEN-1:0]      count;
      logic [`WB_XLEN-1:0]      address;
      logic [`WB_XLEN-1:0]      new_flags;
      // OF, DF, SF, ZF, AF, PF, CF from msb down
      logic [6:0]               flags_affected;
   } wb_uop_t;

   typedef struct packed {
      logic                     en;
      logic [`WB_GPR_IDX_W-1:0] idx;
      logic [`WB_XLEN-1:0]      data;
   } gpr_wr_t;

   // wishbone classic
   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [`WB_XLEN-1:0] adr;
      logic [`WB_XLEN-1:0] dat;
      logic [3:0]          sel;
   } wbm_req_t;

   typedef struct packed {
      logic                ack;
      logic [`WB_XLEN-1:0] dat;
   } wbm_rsp_t;

endpackage

//--- common/wb_stage_params.svh
// writeback stage parameters
`ifndef WB_STAGE_PARAMS_SVH
`define WB_STAGE_PARAMS_SVH

// datapath and storage sizes
`define WB_XLEN       32
`define WB_NUM_GPR    8
`define WB_GPR_IDX_W  3
`define WB_MEM_WORDS  256

// flag bit positions in the 32-bit flags register
`define WB_FLAG_OF    11
`define WB_FLAG_DF    10
`define WB_FLAG_SF    7
`define WB_FLAG_ZF    6
`define WB_FLAG_AF    4
`define WB_FLAG_PF    2
`define WB_FLAG_CF    0

`endif
